/* aether_engine.f */
src/aether_pkg.sv
src/conv_ctrl_if.sv
src/aether_engine_decoder.sv
src/input_buffer.sv
src/conv_weight_store.sv
src/convolution_layer.sv
src/result_fifo.sv
src/aether_engine.sv
sim/aether_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f aether_engine.f \
  --top-module aether_engine_tb -o aether_engine_sim

output=$(./obj_dir/aether_engine_sim 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Finished with no errors"

/* sim/aether_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aether_engine_tb
  import aether_pkg::*;
;

  localparam int ResultDepth = 4;
  localparam int NumTests    = 4;

  logic       clk_i;
  logic       rst_n_i;
  logic [3:0] instruction_i;
  logic [3:0] param_1_i;
  word_t      param_2_i;
  word_t      data_o;
  logic       interrupt_o;

  logic [31:0] lcg_state = 32'd81487;
  act_t        mat [64];  // Row-major activation bytes
  act_t        wgt [10];  // Tap 9 pads the last weight word

  // Test table with one column per field
  string test_name [NumTests] = '{"small_3x3", "mixed_4x4", "sat_6x6", "backpr_8x8"};
  int    test_size [NumTests] = '{3, 4, 6, 8};
  int    pix_lo    [NumTests] = '{-128, -128, 64, -128};
  int    pix_span  [NumTests] = '{256, 256, 64, 256};
  int    wgt_lo    [NumTests] = '{-4, -128, 64, -128};  // Weight scale
  int    wgt_span  [NumTests] = '{8, 256, 64, 256};

  aether_engine #(.MaxMatrixSize(8), .ResultDepth(ResultDepth)) DUT (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic act_t rand_byte(input int lo, input int span);
    logic [31:0] r;
    r = next_rand();
    return act_t'(lo + int'(r[23:8]) % span);  // Byte from the upper LCG bits
  endfunction

  // Saturated 3x3 sum at output position (r, c)
  function automatic word_t conv_ref(input int size, input int r, input int c);
    int sum;
    sum = 0;
    for (int kr = 0; kr < 3; kr++) begin
      for (int kc = 0; kc < 3; kc++) begin
        sum += int'(wgt[kr * 3 + kc]) * int'(mat[(r + kr) * size + c + kc]);
      end
    end
    if (sum > 32767) sum = 32767;
    else if (sum < -32768) sum = -32768;
    return word_t'(sum);
  endfunction

  task automatic check_equal(input string label, input word_t expected, input word_t actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED %s expected %h actual %h", label, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Mismatch in %s", label);
    end
  endtask

  // Drives one command for a single cycle starting 1 ns after the edge
  task automatic issue(input logic [3:0] instr, input logic [3:0] idx, input word_t data);
    instruction_i = instr;
    param_1_i     = idx;
    param_2_i     = data;
    @(posedge clk_i);
    #1;
    instruction_i = NOP;
    param_1_i     = '0;
    param_2_i     = '0;
  endtask

  task automatic read_reg(input logic [3:0] idx, output word_t value);
    issue(RD_REG, idx, '0);
    value = data_o;  // Updated on the edge just passed
  endtask

  // ------------------------------------------------------------
  // One table entry
  // ------------------------------------------------------------
  task automatic run_test(input int t);
    int    size;
    int    nres;
    int    got;
    word_t rd;
    word_t expected [36];
    size = test_size[t];
    nres = (size - 2) * (size - 2);
    issue(WR_REG, REG_BCFG2, word_t'(size));
    read_reg(REG_BCFG2, rd);
    check_equal($sformatf("%s size", test_name[t]), word_t'(size), rd);

    for (int i = 0; i < 64; i++) begin
      mat[i] = '0;
      if (i < size * size) mat[i] = rand_byte(pix_lo[t], pix_span[t]);
    end
    for (int k = 0; k < 10; k++) begin
      wgt[k] = '0;
      if (k < 9) wgt[k] = rand_byte(wgt_lo[t], wgt_span[t]);
    end

    // Two bytes per word with the even byte low
    for (int i = 0; i < (size * size + 1) / 2; i++) begin
      issue((i == 0) ? LIP_STRT : LIP_CONT, '0, {mat[2 * i + 1], mat[2 * i]});
    end
    for (int k = 0; k < 5; k++) issue(LDW_CONT, '0, {wgt[2 * k + 1], wgt[2 * k]});

    for (int r = 0; r < size - 2; r++) begin
      for (int c = 0; c < size - 2; c++) expected[r * (size - 2) + c] = conv_ref(size, r, c);
    end

    issue(CNV_RUN, '0, '0);
    if (nres > ResultDepth) begin
      while (!interrupt_o) begin  // Queue fills while the engine stalls
        @(posedge clk_i);
        #1;
      end
      read_reg(REG_STATS, rd);
      check_equal($sformatf("%s stalled status", test_name[t]), 16'h000D, rd);
    end

    got = 0;
    while (got < nres) begin
      read_reg(REG_STATS, rd);
      if (rd[2]) begin  // Not empty
        issue(RD_RSLT, '0, '0);
        check_equal($sformatf("%s result %0d", test_name[t], got), expected[got], data_o);
        got++;
      end
    end

    rd = '0;
    while (!rd[1]) read_reg(REG_STATS, rd);  // Wait for done
    check_equal($sformatf("%s final status", test_name[t]), 16'h0002, rd);
    issue(RD_RSLT, '0, '0);
    check_equal($sformatf("%s empty pop", test_name[t]), 16'h0000, data_o);
    check_equal($sformatf("%s interrupt", test_name[t]), 16'h0000, word_t'(interrupt_o));
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    word_t rd;
    rst_n_i       = 1'b0;
    instruction_i = NOP;
    param_1_i     = '0;
    param_2_i     = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    check_equal("reset data_o", 16'h0000, data_o);
    check_equal("reset interrupt", 16'h0000, word_t'(interrupt_o));
    read_reg(REG_VERSN, rd);
    check_equal("version reg", 16'h6C00, rd);
    read_reg(REG_HWRID, rd);
    check_equal("hw id reg", 16'hB2E9, rd);
    read_reg(REG_BCFG2, rd);
    check_equal("default size", 16'h0004, rd);
    read_reg(REG_STATS, rd);
    check_equal("reset status", 16'h0000, rd);
    read_reg(4'd9, rd);  // Unmapped index
    check_equal("unmapped reg", 16'h0000, rd);

    for (int t = 0; t < NumTests; t++) run_test(t);

    $display("Finished with no errors");
    $finish;
  end

  // Budget of 200 cycles plus 15 per expected result
  initial begin
    int cycles;
    cycles = 200;
    for (int t = 0; t < NumTests; t++) begin
      cycles += 15 * (test_size[t] - 2) * (test_size[t] - 2);
    end
    repeat (cycles) @(posedge clk_i);
    $display("ERROR: run timed out after %0d cycles", cycles);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

/* src/aether_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module aether_engine
  import aether_pkg::*;
#(
  parameter int unsigned MaxMatrixSize = 8,
  parameter int unsigned ResultDepth   = 4
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [3:0] instruction_i,
  input  logic [3:0] param_1_i,
  input  word_t      param_2_i,
  output word_t      data_o,
  output logic       interrupt_o   // Result queue full
);

  localparam int unsigned SizeBits = $clog2(MaxMatrixSize + 1);
  localparam int unsigned AddrBits = $clog2((MaxMatrixSize * MaxMatrixSize + 1) / 2);

  // ------------------------------------------------------------
  // Internal links
  // ------------------------------------------------------------
  logic                buf_start, buf_cont, wgt_shift, pop;
  logic [AddrBits-1:0] buf_raddr;
  word_t               buf_rdata;
  act_t                weights [KernelTaps];
  logic                res_valid, res_ready;
  word_t               res_data, fifo_head;
  logic                fifo_avail, fifo_full;

  conv_ctrl_if #(.SizeBits(SizeBits)) ctrl_if ();

  aether_engine_decoder #(.MaxMatrixSize(MaxMatrixSize)) decode_inst (
    .clk_i, .rst_n_i,
    .instruction_i(instr_e'(instruction_i)),
    .param_1_i, .param_2_i,
    .fifo_head_i(fifo_head), .fifo_avail_i(fifo_avail), .fifo_full_i(fifo_full),
    .data_o, .buf_start_o(buf_start), .buf_cont_o(buf_cont),
    .wgt_shift_o(wgt_shift), .pop_o(pop), .interrupt_o,
    .ctrl(ctrl_if.decoder)
  );

  // Activation matrix storage
  input_buffer #(.MaxMatrixSize(MaxMatrixSize)) buffer_inst (
    .clk_i, .rst_n_i, .start_i(buf_start), .cont_i(buf_cont),
    .wdata_i(param_2_i), .raddr_i(buf_raddr), .rdata_o(buf_rdata)
  );

  conv_weight_store weight_inst (
    .clk_i, .rst_n_i, .shift_i(wgt_shift), .wdata_i(param_2_i), .weights_o(weights)
  );

  convolution_layer #(.MaxMatrixSize(MaxMatrixSize)) conv_inst (
    .clk_i, .rst_n_i, .weights_i(weights), .rdata_i(buf_rdata),
    .result_ready_i(res_ready), .raddr_o(buf_raddr),
    .result_valid_o(res_valid), .result_data_o(res_data),
    .ctrl(ctrl_if.engine)
  );

  // Results wait here for RD_RSLT
  result_fifo #(.ResultDepth(ResultDepth)) fifo_inst (
    .clk_i, .rst_n_i, .in_valid_i(res_valid), .in_data_i(res_data), .pop_i(pop),
    .in_ready_o(res_ready), .head_o(fifo_head), .avail_o(fifo_avail), .full_o(fifo_full)
  );

endmodule

`default_nettype wire

/* src/aether_engine_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aether_engine_decoder
  import aether_pkg::*;
#(
  parameter int unsigned MaxMatrixSize = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  instr_e     instruction_i,
  input  logic [3:0] param_1_i,    // Register index
  input  word_t      param_2_i,    // Write data
  input  word_t      fifo_head_i,
  input  logic       fifo_avail_i,
  input  logic       fifo_full_i,
  output word_t      data_o,
  output logic       buf_start_o,
  output logic       buf_cont_o,
  output logic       wgt_shift_o,
  output logic       pop_o,
  output logic       interrupt_o,
  conv_ctrl_if.decoder ctrl
);

  localparam int unsigned SizeBits = $clog2(MaxMatrixSize + 1);

  reg_idx_e            reg_idx;
  logic [SizeBits-1:0] bcfg2_q;   // Matrix size register
  word_t               status;
  word_t               reg_rdata;

  assign reg_idx = reg_idx_e'(param_1_i);

  // ------------------------------------------------------------
  // Command strobes
  // ------------------------------------------------------------
  assign buf_start_o = (instruction_i == LIP_STRT);
  assign buf_cont_o  = (instruction_i == LIP_CONT);
  assign wgt_shift_o = (instruction_i == LDW_CONT);
  assign pop_o       = (instruction_i == RD_RSLT) && fifo_avail_i;  // Never pop empty queue
  assign ctrl.start  = (instruction_i == CNV_RUN);

  assign ctrl.matrix_size = bcfg2_q;
  assign interrupt_o      = fifo_full_i;  // Host must drain results

  // Status word
  always_comb begin
    status               = '0;
    status[STAT_RUNNING] = ctrl.running;
    status[STAT_DONE]    = ctrl.done;
    status[STAT_AVAIL]   = fifo_avail_i;
    status[STAT_FULL]    = fifo_full_i;
  end

  // Register read mux
  always_comb begin
    case (reg_idx)
      REG_VERSN: reg_rdata = VersionValue;
      REG_HWRID: reg_rdata = HwIdValue;
      REG_BCFG2: reg_rdata = word_t'(bcfg2_q);
      REG_STATS: reg_rdata = status;
      default:   reg_rdata = '0;  // Unmapped indices
    endcase
  end

  // ------------------------------------------------------------
  // Registered output and config register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_o  <= '0;
      bcfg2_q <= SizeBits'(4);  // Default 4x4 matrix
    end else begin
      case (instruction_i)
        RD_REG:  data_o <= reg_rdata;
        RD_RSLT: data_o <= fifo_avail_i ? fifo_head_i : '0;  // Empty reads as zero
        WR_REG: begin
          // Size frozen while the engine walks the matrix
          if (reg_idx == REG_BCFG2 && !ctrl.running) begin
            bcfg2_q <= param_2_i[SizeBits-1:0];
          end
        end
        default: ;  // data_o holds
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/aether_pkg.sv */
`default_nettype none

package aether_pkg;

  // ------------------------------------------------------------
  // Command set
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    NOP      = 4'd0,
    RD_REG   = 4'd1,  // Register read into data_o
    WR_REG   = 4'd2,
    LIP_STRT = 4'd3,  // First activation word
    LIP_CONT = 4'd4,
    LDW_CONT = 4'd5,  // Weight word shift in
    CNV_RUN  = 4'd6,
    RD_RSLT  = 4'd7   // Pop one result
  } instr_e;

  typedef enum logic [3:0] {
    REG_VERSN = 4'd0,
    REG_HWRID = 4'd1,
    REG_BCFG2 = 4'd2,  // Matrix size
    REG_STATS = 4'd3
  } reg_idx_e;

  // Data types
  typedef logic [15:0]        word_t;  // Command and result bus word
  typedef logic signed [7:0]  act_t;   // Activation or weight byte
  typedef logic signed [19:0] acc_t;   // MAC accumulator

  // Kernel geometry
  localparam int unsigned KernelSize  = 3;
  localparam int unsigned KernelTaps  = KernelSize * KernelSize;
  localparam int unsigned WeightWords = (KernelTaps + 1) / 2;  // Two taps per word

  // ID register contents
  localparam word_t VersionValue = 16'h6C00;
  localparam word_t HwIdValue    = 16'hB2E9;

  // Status word bit positions
  localparam int unsigned STAT_RUNNING = 0;
  localparam int unsigned STAT_DONE    = 1;
  localparam int unsigned STAT_AVAIL   = 2;
  localparam int unsigned STAT_FULL    = 3;

endpackage

`default_nettype wire

/* src/conv_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoder to convolution engine control link
interface conv_ctrl_if #(
  parameter int unsigned SizeBits = 4
);
  logic                start;        // One cycle run request
  logic [SizeBits-1:0] matrix_size;  // Stable during a run
  logic                running;
  logic                done;         // Sticky until next start

  modport decoder (output start, output matrix_size, input running, input done);
  modport engine (input start, input matrix_size, output running, output done);
endinterface

`default_nettype wire

/* src/conv_weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_weight_store
  import aether_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  shift_i,
  input  word_t wdata_i,
  output act_t  weights_o [KernelTaps]
);

  word_t store_q [WeightWords];  // Word 0 is the oldest load

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < WeightWords; i++) store_q[i] <= '0;
    end else if (shift_i) begin
      for (int i = 0; i < WeightWords - 1; i++) store_q[i] <= store_q[i+1];
      store_q[WeightWords-1] <= wdata_i;  // New word enters at the top
    end
  end

  // Even taps in low byte, odd taps in high byte
  always_comb begin
    for (int k = 0; k < KernelTaps; k++) begin
      weights_o[k] = k[0] ? act_t'(store_q[k/2][15:8]) : act_t'(store_q[k/2][7:0]);
    end
  end

endmodule

`default_nettype wire

/* src/convolution_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module convolution_layer
  import aether_pkg::*;
#(
  parameter int unsigned MaxMatrixSize = 8,
  localparam int unsigned AddrBits = $clog2((MaxMatrixSize * MaxMatrixSize + 1) / 2)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  act_t                weights_i [KernelTaps],
  input  word_t               rdata_i,         // Word for last cycle's address
  input  logic                result_ready_i,
  output logic [AddrBits-1:0] raddr_o,
  output logic                result_valid_o,
  output word_t               result_data_o,
  conv_ctrl_if.engine ctrl
);

  localparam int unsigned SizeBits = $clog2(MaxMatrixSize + 1);
  localparam int unsigned ByteBits = AddrBits + 1;
  localparam acc_t SatMax = acc_t'(32767);
  localparam acc_t SatMin = acc_t'(-32768);

  typedef enum logic [2:0] {S_IDLE, S_FETCH, S_MAC, S_EMIT, S_FINISH} state_e;

  state_e              state;
  logic [SizeBits-1:0] row, col;       // Output position
  logic [SizeBits-1:0] last_pos;
  logic [1:0]          ikr, ikc;       // Kernel offset being addressed
  logic [1:0]          ikr_nxt, ikc_nxt;
  logic [3:0]          tap;            // Tap being accumulated
  logic [ByteBits-1:0] pix_r, pix_c, byte_idx;
  logic                sel_q;          // High byte of returned word
  logic                done_q;
  act_t                pix;
  logic signed [15:0]  prod;
  acc_t                acc;

  assign last_pos = ctrl.matrix_size - SizeBits'(3);  // Last valid row or column

  // ------------------------------------------------------------
  // Address generation
  // ------------------------------------------------------------
  assign pix_r    = ByteBits'(row) + ByteBits'(ikr);
  assign pix_c    = ByteBits'(col) + ByteBits'(ikc);
  assign byte_idx = pix_r * ByteBits'(ctrl.matrix_size) + pix_c;  // Row-major byte
  assign raddr_o  = byte_idx[ByteBits-1:1];

  // Kernel offset walk in tap order
  always_comb begin
    ikr_nxt = ikr;
    ikc_nxt = ikc + 1'b1;
    if (ikc == 2'(KernelSize - 1)) begin
      ikc_nxt = '0;
      ikr_nxt = ikr + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state  <= S_IDLE;
      done_q <= 1'b0;
      row    <= '0;
      col    <= '0;
      tap    <= '0;
      ikr    <= '0;
      ikc    <= '0;
    end else begin
      case (state)
        S_IDLE: if (ctrl.start) begin
          state  <= S_FETCH;
          done_q <= 1'b0;
          row    <= '0;
          col    <= '0;
          ikr    <= '0;
          ikc    <= '0;
        end
        S_FETCH: begin  // Tap 0 address out
          tap   <= '0;
          ikr   <= ikr_nxt;
          ikc   <= ikc_nxt;
          state <= S_MAC;
        end
        S_MAC: begin  // Accumulate one tap and address the next
          if (tap == 4'(KernelTaps - 1)) begin
            ikr   <= '0;
            ikc   <= '0;
            state <= S_EMIT;
          end else begin
            tap <= tap + 1'b1;
            ikr <= ikr_nxt;
            ikc <= ikc_nxt;
          end
        end
        S_EMIT: if (result_ready_i) begin  // Stall here on back-pressure
          state <= S_FETCH;
          if (col == last_pos) begin
            col <= '0;
            if (row == last_pos) state <= S_FINISH;
            else row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
        end
        S_FINISH: begin
          done_q <= 1'b1;
          state  <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  assign pix  = sel_q ? act_t'(rdata_i[15:8]) : act_t'(rdata_i[7:0]);
  assign prod = pix * weights_i[tap];

  always_ff @(posedge clk_i) begin
    sel_q <= byte_idx[0];
    if (state == S_FETCH) acc <= '0;
    else if (state == S_MAC) acc <= acc + acc_t'(prod);
  end

  // Clamp to signed 16 bits
  always_comb begin
    if (acc > SatMax)      result_data_o = 16'h7FFF;
    else if (acc < SatMin) result_data_o = 16'h8000;
    else                   result_data_o = acc[15:0];
  end

  assign result_valid_o = (state == S_EMIT);
  assign ctrl.running   = (state != S_IDLE);
  assign ctrl.done      = done_q;

endmodule

`default_nettype wire

/* src/input_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module input_buffer
  import aether_pkg::*;
#(
  parameter int unsigned MaxMatrixSize = 8,
  localparam int unsigned Words    = (MaxMatrixSize * MaxMatrixSize + 1) / 2,
  localparam int unsigned AddrBits = $clog2(Words)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,   // Write word 0
  input  logic                cont_i,    // Write next word
  input  word_t               wdata_i,
  input  logic [AddrBits-1:0] raddr_i,
  output word_t               rdata_o
);

  word_t               mem [Words];
  logic [AddrBits-1:0] waddr_q;  // Last written word
  logic [AddrBits-1:0] wr_addr;

  // Saturating load pointer
  assign wr_addr = start_i ? '0 :
                   (waddr_q == AddrBits'(Words - 1)) ? waddr_q : waddr_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      waddr_q <= '0;
    end else if (start_i || cont_i) begin
      waddr_q <= wr_addr;
    end
  end

  // Storage and one cycle read
  always_ff @(posedge clk_i) begin
    if (start_i || cont_i) begin
      mem[wr_addr] <= wdata_i;
    end
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

/* src/result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module result_fifo
  import aether_pkg::*;
#(
  parameter int unsigned ResultDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  in_valid_i,
  input  word_t in_data_i,
  input  logic  pop_i,
  output logic  in_ready_o,
  output word_t head_o,
  output logic  avail_o,
  output logic  full_o
);

  localparam int unsigned PtrBits = $clog2(ResultDepth);
  localparam int unsigned CntBits = $clog2(ResultDepth + 1);

  word_t              mem [ResultDepth];
  logic [PtrBits-1:0] wptr, rptr;
  logic [CntBits-1:0] count;
  logic               push, pop;

  assign avail_o    = (count != '0);
  assign full_o     = (count == CntBits'(ResultDepth));
  assign in_ready_o = !full_o;          // Back-pressure to the engine
  assign push       = in_valid_i && in_ready_o;
  assign pop        = pop_i && avail_o;
  assign head_o     = mem[rptr];

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) wptr <= (wptr == PtrBits'(ResultDepth - 1)) ? '0 : wptr + 1'b1;
      if (pop)  rptr <= (rptr == PtrBits'(ResultDepth - 1)) ? '0 : rptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;  // Both at once keeps level
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wptr] <= in_data_i;
  end

endmodule

`default_nettype wire
